// File: design/linkSpiPkg.sv
// Service protocol types shared by the SPI link blocks.
package linkSpiPkg;

	// service command codes, carried in the low byte of a header word.
	typedef enum logic [7:0] {
		TCC_RESET   = 8'h01, // clear the remote side.
		TCC_SEND    = 8'h02, // data for the 1553 side.
		TCC_RECEIVE = 8'h03, // request buffered 1553 data.
		TCC_STATUS  = 8'h04  // request link status.
	} TCommandCode;

	// a protocol word is either plain data or a packet header.
	typedef union packed {
		logic [15:0] raw;
		struct packed {
			logic [7:0]  addr;    // upper byte.
			TCommandCode cmdCode; // lower byte.
		} hdr;
	} TServiceWord;

	// packet layout on the wire:
	//   header, size N, N data words, checksum.
	// the checksum is the 16-bit wrapping sum of every word before it.

	typedef enum logic [1:0] {
		DS_HEADER,   // waiting for address and command.
		DS_SIZE,     // waiting for the word count.
		DS_DATA,     // passing data words to the host.
		DS_CHECKSUM  // last word of the packet.
	} TDecodeState;

	typedef enum logic [2:0] {
		ES_IDLE,     // no reply in progress.
		ES_HEADER,   // header word pushed.
		ES_SIZE,     // size word pushed.
		ES_POP,      // host data requested.
		ES_DATA,     // host data pushed.
		ES_CHECKSUM  // checksum pushed.
	} TEncodeState;

endpackage

// File: design/linkIf.sv
`timescale 1ns/100ps
// Internal buses of the SPI link, received word stream and transmit queue write port.

// words framed by the spi slave, consumed by the decoder.
interface spiWordIf();
	logic [15:0] rxWord;     // last complete word.
	logic        rxStrobe;   // one cycle per received word.
	logic        frameStart; // csN went low.
	logic        frameEnd;   // csN went high.

	modport source(
		output rxWord, rxStrobe, frameStart, frameEnd
	);

	modport sink(
		input  rxWord, rxStrobe, frameStart, frameEnd
	);
endinterface

// packet words from the encoder into the transmit queue.
interface txQueueIf();
	logic [15:0] txWord;
	logic        txPush;     // no back-pressure.
	logic        txFull;
	logic        txOverflow; // sticky until reset.

	modport writer(
		output txWord, txPush,
		input  txFull, txOverflow
	);

	modport store(
		input  txWord, txPush,
		output txFull, txOverflow
	);
endinterface

// File: design/spiSlave.sv
`timescale 1ns/100ps
// SPI mode 0 slave, samples the bus on clk and frames 16-bit words MSB first.
module spiSlave import linkSpiPkg::*; #(
	parameter int TX_DEPTH = 16
) (
	input  logic        clk,
	input  logic        rstN,
	input  logic        sclk,
	input  logic        mosi,
	input  logic        csN,
	output logic        miso,
	spiWordIf.source    wordBus,
	input  TServiceWord popWord,
	output logic        popStrobe,
	input  logic        queueEmpty,
	output logic        spiIsBusy,
	output logic        inQueueOverflow
);
	logic [2:0]  sclkSync;  // two sync stages plus one for edge detect.
	logic [2:0]  csSync;
	logic [1:0]  mosiSync;
	logic        sclkRise;
	logic        sclkFall;
	logic        csActive;
	logic        wordStart;
	logic [3:0]  bitCnt;    // bit position inside the current word.
	logic [14:0] rxShift;
	logic [15:0] txShift;
	logic        txLoaded;  // current tx word came from the queue.

	// the queue pointers wrap naturally only for power of two depths.
	if (TX_DEPTH < 2 || (TX_DEPTH & (TX_DEPTH - 1)) != 0) begin : gDepthCheck
		$error("spiSlave: TX_DEPTH must be a power of two");
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			sclkSync <= '0;
			csSync <= '1;
			mosiSync <= '0;
		end else begin
			sclkSync <= {sclkSync[1:0], sclk};
			csSync <= {csSync[1:0], csN};
			mosiSync <= {mosiSync[0], mosi};
		end
	end

	assign sclkRise = sclkSync[1] & ~sclkSync[2];
	assign sclkFall = ~sclkSync[1] & sclkSync[2];
	assign csActive = ~csSync[1];
	assign spiIsBusy = csActive;

	assign wordBus.frameStart = csSync[2] & ~csSync[1];
	assign wordBus.frameEnd = ~csSync[2] & csSync[1];

	// receive side.
	always_ff @(posedge clk) begin
		if (!rstN) begin
			bitCnt <= '0;
			wordBus.rxStrobe <= 1'b0;
			inQueueOverflow <= 1'b0;
		end else begin
			wordBus.rxStrobe <= csActive && sclkRise && bitCnt == 4'd15;
			if (wordBus.frameStart)
				bitCnt <= '0;
			else if (csActive && sclkRise)
				bitCnt <= bitCnt + 4'd1;
			if (wordBus.frameEnd && bitCnt != '0)
				inQueueOverflow <= 1'b1; // frame cut a word short.
		end
	end

	always_ff @(posedge clk) begin
		if (csActive && sclkRise) begin
			rxShift <= {rxShift[13:0], mosiSync[1]};
			if (bitCnt == 4'd15)
				wordBus.rxWord <= {rxShift, mosiSync[1]};
		end
	end

	// a new tx word starts at csN low and at the falling edge after each 16th bit.
	assign wordStart = wordBus.frameStart || (csActive && sclkFall && bitCnt == '0);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			txShift <= '0;
			txLoaded <= 1'b0;
		end else if (wordStart) begin
			txShift <= queueEmpty ? '0 : popWord.raw; // zeros when nothing to send.
			txLoaded <= !queueEmpty;
		end else if (wordBus.frameEnd) begin
			txShift <= '0;
		end else if (csActive && sclkFall) begin
			txShift <= {txShift[14:0], 1'b0};
		end
	end

	// the head word leaves the queue once the master clocks its first bit,
	// so a trailing falling edge at the end of a frame loses nothing.
	assign popStrobe = txLoaded && csActive && sclkRise && bitCnt == '0;

	assign miso = txShift[15];

endmodule

// File: design/txWordQueue.sv
`timescale 1ns/100ps
// Transmit FIFO holding packet words until the SPI slave shifts them out.
module txWordQueue import linkSpiPkg::*; #(
	parameter int TX_DEPTH = 16
) (
	input  logic        clk,
	input  logic        rstN,
	txQueueIf.store     writeBus,
	output TServiceWord popWord,
	input  logic        popStrobe,
	output logic        queueEmpty
);
	localparam int PTR_W = $clog2(TX_DEPTH);

	TServiceWord      mem [TX_DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [PTR_W:0]   count;
	logic             doPush;
	logic             doPop;

	assign writeBus.txFull = count == (PTR_W + 1)'(TX_DEPTH);
	assign queueEmpty = count == '0;
	assign doPush = writeBus.txPush && !writeBus.txFull; // full queue drops the word.
	assign doPop = popStrobe && !queueEmpty;
	assign popWord = mem[rdPtr]; // head is visible before the pop.

	always_ff @(posedge clk) begin
		if (doPush)
			mem[wrPtr].raw <= writeBus.txWord;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			writeBus.txOverflow <= 1'b0;
		end else begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
			if (writeBus.txPush && writeBus.txFull)
				writeBus.txOverflow <= 1'b1;
		end
	end

endmodule

// File: design/protocolDecoder.sv
`timescale 1ns/100ps
// Service protocol decoder, splits received words into packets and checks the checksum.
module protocolDecoder import linkSpiPkg::*; (
	input  logic        clk,
	input  logic        rstN,
	spiWordIf.sink      wordBus,
	output logic [15:0] pushData,
	output logic        pushStrobe,
	output logic [7:0]  inAddr,
	output logic [7:0]  inWordNum,
	output TCommandCode inCmdCode,
	output logic        inPacketStart,
	output logic        inPacketEnd,
	output logic        inPacketErr
);
	TDecodeState state;
	TServiceWord rxView;
	logic [15:0] remaining; // data words still expected.
	logic [15:0] checksum;
	logic [7:0]  dataIdx;

	assign rxView.raw = wordBus.rxWord;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= DS_HEADER;
			pushStrobe <= 1'b0;
			inPacketStart <= 1'b0;
			inPacketEnd <= 1'b0;
			inPacketErr <= 1'b0;
		end else begin
			pushStrobe <= 1'b0;
			inPacketStart <= 1'b0;
			inPacketEnd <= 1'b0;
			inPacketErr <= 1'b0;

			if (wordBus.frameStart) begin
				state <= DS_HEADER;
			end else if (wordBus.frameEnd) begin
				if (state != DS_HEADER)
					inPacketErr <= 1'b1; // packet broken off by csN.
				state <= DS_HEADER;
			end else if (wordBus.rxStrobe) begin
				case (state)
					DS_HEADER: begin
						inAddr <= rxView.hdr.addr;
						inCmdCode <= rxView.hdr.cmdCode;
						checksum <= rxView.raw;
						inPacketStart <= 1'b1;
						state <= DS_SIZE;
					end
					DS_SIZE: begin
						remaining <= rxView.raw;
						checksum <= checksum + rxView.raw;
						dataIdx <= '0;
						// empty packets carry only the checksum.
						state <= (rxView.raw == '0) ? DS_CHECKSUM : DS_DATA;
					end
					DS_DATA: begin
						pushData <= rxView.raw;
						pushStrobe <= 1'b1;
						inWordNum <= dataIdx;
						dataIdx <= dataIdx + 8'd1;
						checksum <= checksum + rxView.raw;
						remaining <= remaining - 16'd1;
						if (remaining == 16'd1)
							state <= DS_CHECKSUM;
					end
					DS_CHECKSUM: begin
						inPacketEnd <= 1'b1;
						inPacketErr <= rxView.raw != checksum;
						state <= DS_HEADER;
					end
					default: state <= DS_HEADER;
				endcase
			end
		end
	end

endmodule

// File: design/protocolEncoder.sv
`timescale 1ns/100ps
// Service protocol encoder, builds a reply packet from host data into the transmit queue.
module protocolEncoder import linkSpiPkg::*; (
	input  logic        clk,
	input  logic        rstN,
	input  logic        outEnable,
	input  logic [7:0]  outAddr,
	input  TCommandCode outCmdCode,
	input  logic [15:0] outDataSize,
	output logic        popStrobe,
	input  logic [15:0] popData,
	output logic        outBusy,
	txQueueIf.writer    writeBus
);
	TEncodeState state;
	TServiceWord reqHeader;
	logic [15:0] dataSize;
	logic [15:0] remaining; // data words left to fetch.
	logic [15:0] checksum;

	assign outBusy = state != ES_IDLE;
	assign popStrobe = state == ES_POP;
	assign writeBus.txPush = state inside {ES_HEADER, ES_SIZE, ES_DATA, ES_CHECKSUM};

	always_comb begin
		case (state)
			ES_HEADER:   writeBus.txWord = reqHeader.raw;
			ES_SIZE:     writeBus.txWord = dataSize;
			ES_CHECKSUM: writeBus.txWord = checksum;
			default:     writeBus.txWord = popData; // host answers one cycle after the pop.
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= ES_IDLE;
		end else begin
			if (writeBus.txPush)
				checksum <= checksum + writeBus.txWord;

			case (state)
				ES_IDLE: begin
					if (outEnable) begin
						reqHeader.hdr.addr <= outAddr;
						reqHeader.hdr.cmdCode <= outCmdCode;
						dataSize <= outDataSize;
						remaining <= outDataSize;
						checksum <= '0;
						state <= ES_HEADER;
					end
				end
				ES_HEADER: state <= ES_SIZE;
				ES_SIZE:   state <= (remaining == '0) ? ES_CHECKSUM : ES_POP;
				ES_POP:    state <= ES_DATA;
				ES_DATA: begin
					remaining <= remaining - 16'd1;
					state <= (remaining == 16'd1) ? ES_CHECKSUM : ES_POP;
				end
				ES_CHECKSUM: state <= ES_IDLE;
				default:     state <= ES_IDLE;
			endcase
		end
	end

endmodule

// File: design/linkSpi.sv
`timescale 1ns/100ps
// SPI link layer top, joins the SPI slave, transmit queue, decoder and encoder.
module linkSpi import linkSpiPkg::*; #(
	parameter int TX_DEPTH = 16
) (
	input  logic        clk,
	input  logic        rstN,
	input  logic        sclk,
	input  logic        mosi,
	input  logic        csN,
	output logic        miso,
	output logic [15:0] pushData,
	output logic        pushStrobe,
	input  logic [15:0] popData,
	output logic        popStrobe,
	output logic [7:0]  inAddr,
	output logic [7:0]  inWordNum,
	output TCommandCode inCmdCode,
	output logic        inPacketStart,
	output logic        inPacketEnd,
	output logic        inPacketErr,
	input  logic        outEnable,
	input  logic [7:0]  outAddr,
	input  TCommandCode outCmdCode,
	input  logic [15:0] outDataSize,
	output logic        outBusy,
	output logic        spiIsBusy,
	output logic        inQueueOverflow,
	output logic        outQueueOverflow
);
	spiWordIf    wordBus();
	txQueueIf    queueBus();
	TServiceWord queueWord;  // head of the transmit queue.
	logic        queuePop;
	logic        queueEmpty;

	spiSlave #(.TX_DEPTH(TX_DEPTH)) slave (
		.clk(clk), .rstN(rstN),
		.sclk(sclk), .mosi(mosi), .csN(csN), .miso(miso),
		.wordBus(wordBus.source),
		.popWord(queueWord), .popStrobe(queuePop), .queueEmpty(queueEmpty),
		.spiIsBusy(spiIsBusy), .inQueueOverflow(inQueueOverflow)
	);

	txWordQueue #(.TX_DEPTH(TX_DEPTH)) txQueue (
		.clk(clk), .rstN(rstN),
		.writeBus(queueBus.store),
		.popWord(queueWord), .popStrobe(queuePop), .queueEmpty(queueEmpty)
	);

	protocolDecoder decoder (
		.clk(clk), .rstN(rstN),
		.wordBus(wordBus.sink),
		.pushData(pushData), .pushStrobe(pushStrobe),
		.inAddr(inAddr), .inWordNum(inWordNum), .inCmdCode(inCmdCode),
		.inPacketStart(inPacketStart), .inPacketEnd(inPacketEnd), .inPacketErr(inPacketErr)
	);

	protocolEncoder encoder (
		.clk(clk), .rstN(rstN),
		.outEnable(outEnable), .outAddr(outAddr), .outCmdCode(outCmdCode),
		.outDataSize(outDataSize),
		.popStrobe(popStrobe), .popData(popData),
		.outBusy(outBusy),
		.writeBus(queueBus.writer)
	);

	assign outQueueOverflow = queueBus.txOverflow; // sticky in the queue.

endmodule

// File: sim/linkSpi_sva.sv
`timescale 1ns/100ps
// Concurrent checks on the SPI link status pulses, encoder push timing and queue pops.
module linkSpiSva (
	input logic clk,
	input logic rstN,
	input logic pushStrobe,
	input logic inPacketEnd,
	input logic inPacketErr,
	input logic outBusy,
	input logic popStrobe,
	input logic txPush,
	input logic queuePop,
	input logic queueEmpty
);
	int failCount = 0; // failed assertions so far.

	statusApartFromPush: assert property (@(posedge clk) disable iff (!rstN)
		(inPacketEnd || inPacketErr) |-> !pushStrobe)
		else begin
			$error("packet status pulse in the same cycle as pushStrobe");
			failCount++;
		end

	// header and size go out back to back right after the request.
	headerThenSize: assert property (@(posedge clk) disable iff (!rstN)
		$rose(outBusy) |-> txPush ##1 txPush)
		else begin
			$error("header and size words not pushed on consecutive cycles");
			failCount++;
		end

	dataAfterPop: assert property (@(posedge clk) disable iff (!rstN)
		popStrobe |=> txPush)
		else begin
			$error("host data not pushed one cycle after popStrobe");
			failCount++;
		end

	checksumLast: assert property (@(posedge clk) disable iff (!rstN)
		$fell(outBusy) |-> $past(txPush))
		else begin
			$error("encoder went idle without pushing the checksum");
			failCount++;
		end

	busyAfterReset: assert property (@(posedge clk) !rstN |=> !outBusy)
		else begin
			$error("outBusy high after reset");
			failCount++;
		end

	popNotEmpty: assert property (@(posedge clk) disable iff (!rstN)
		queuePop |-> !queueEmpty)
		else begin
			$error("transmit queue popped while empty");
			failCount++;
		end

endmodule

bind linkSpi linkSpiSva svaChecks (
	.clk(clk), .rstN(rstN),
	.pushStrobe(pushStrobe), .inPacketEnd(inPacketEnd), .inPacketErr(inPacketErr),
	.outBusy(outBusy), .popStrobe(popStrobe), .txPush(queueBus.txPush),
	.queuePop(queuePop), .queueEmpty(queueEmpty)
);

// File: sim/linkSpiTb.sv
`timescale 1ns/100ps
// Testbench for the SPI link, runs an SPI master and a host model against linkSpi.
module linkSpiTb import linkSpiPkg::*; ();
	localparam int TIMEOUT = 2000; // clk cycles per wait.

	logic        clk, rstN, sclk, mosi, csN, miso;
	logic [15:0] pushData, popData, outDataSize;
	logic        pushStrobe, popStrobe, inPacketStart, inPacketEnd, inPacketErr;
	logic [7:0]  inAddr, inWordNum, outAddr;
	TCommandCode inCmdCode, outCmdCode;
	logic        outEnable, outBusy, spiIsBusy, inQueueOverflow, outQueueOverflow;

	int          seed = 32'h55d41472;
	logic [15:0] popTable [32]; // host data handed out on pops.
	logic [15:0] txBuf [24];    // words the master sends.
	logic [15:0] rxBuf [24];    // words captured from miso.
	int          popIdx, pushCnt, endCnt, errCnt, bothCnt, popCnt, busyCnt, startCnt;
	int          errors, tests, passed, testErrors;
	string       curTest;

	linkSpi #(.TX_DEPTH(16)) linkSpi_inst (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic waitClocks(input int n);
		repeat (n) @(posedge clk);
		#1; // inputs change just after the edge.
	endtask

	task automatic checkValue(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("error %s %s: expected %h, actual %h", curTest, what, expected, actual);
			errors++;
		end
	endtask

	task automatic reportTimeout(input string what);
		$display("%s: timed out waiting for %s", curTest, what);
		errors++;
	endtask

	task automatic spiWord(input logic [15:0] txWord, output logic [15:0] rxWord);
		for (int i = 15; i >= 0; i--) begin
			mosi = txWord[i];
			waitClocks(4);
			rxWord[i] = miso; // mode 0, captured at the rising edge.
			sclk = 1'b1;
			waitClocks(4);
			sclk = 1'b0;
		end
	endtask

	task automatic spiFrame(input int nWords);
		csN = 1'b0;
		waitClocks(4);
		checkValue("spiIsBusy", 1, spiIsBusy);
		for (int w = 0; w < nWords; w++)
			spiWord(txBuf[w], rxBuf[w]);
		waitClocks(4);
		csN = 1'b1;
		waitClocks(8);
		checkValue("spiIsBusy", 0, spiIsBusy);
	endtask

	task automatic buildPacket(input int nData);
		logic [15:0] sum;
		txBuf[0] = {8'h5a, TCC_SEND};
		txBuf[1] = 16'(nData);
		for (int k = 0; k < nData; k++)
			txBuf[k + 2] = 16'($random(seed));
		sum = 16'h0000;
		for (int k = 0; k < nData + 2; k++)
			sum += txBuf[k]; // wraps at 16 bits.
		txBuf[nData + 2] = sum;
	endtask

	task automatic clearCounts();
		pushCnt = 0;
		endCnt = 0;
		errCnt = 0;
		bothCnt = 0;
		popCnt = 0;
		busyCnt = 0;
		startCnt = 0;
	endtask

	task automatic waitResult();
		int t;
		for (t = 0; t < TIMEOUT && endCnt + errCnt == 0; t++)
			waitClocks(1);
		if (endCnt + errCnt == 0)
			reportTimeout("packet end or error");
		waitClocks(4);
	endtask

	task automatic waitIdle();
		int t;
		for (t = 0; t < TIMEOUT && outBusy; t++)
			waitClocks(1);
		if (outBusy)
			reportTimeout("outBusy to fall");
	endtask

	task automatic requestReply(input logic [15:0] size);
		outAddr = 8'hc3;
		outCmdCode = TCC_STATUS;
		outDataSize = size;
		outEnable = 1'b1;
		waitClocks(1);
		outEnable = 1'b0;
	endtask

	task automatic startTest(input string name);
		curTest = name;
		testErrors = errors;
		clearCounts();
	endtask

	task automatic endTest();
		tests++;
		if (errors == testErrors) begin
			passed++;
			$display("test %s: ok", curTest);
		end else begin
			$display("test %s: failed with %0d errors", curTest, errors - testErrors);
		end
	endtask

	// outputs sampled at the falling edge, half a cycle after they change.
	always @(negedge clk) begin
		if (rstN && pushStrobe) begin
			checkValue("pushData", txBuf[pushCnt + 2], pushData);
			checkValue("inWordNum", pushCnt, inWordNum);
			pushCnt++;
		end
		endCnt += (rstN && inPacketEnd);
		errCnt += (rstN && inPacketErr);
		bothCnt += (rstN && inPacketEnd && inPacketErr);
		popCnt += (rstN && popStrobe);
		busyCnt += (rstN && outBusy);
		startCnt += (rstN && inPacketStart);
	end

	// host answers each pop on the following cycle.
	always @(negedge clk) begin
		if (popStrobe) begin
			waitClocks(1);
			popData = popTable[popIdx % 32];
			popIdx++;
		end
	end

	initial begin
		logic [15:0] expWords [8];
		logic [15:0] sum;
		rstN = 1'b0;
		sclk = 1'b0;
		mosi = 1'b0;
		csN = 1'b1;
		popData = 16'h0000;
		outEnable = 1'b0;
		outAddr = 8'h00;
		outCmdCode = TCC_RESET;
		outDataSize = 16'h0000;
		for (int i = 0; i < 32; i++)
			popTable[i] = 16'($random(seed));
		waitClocks(5);
		rstN = 1'b1;
		waitClocks(2);

		startTest("goodPacket");
		buildPacket(5);
		spiFrame(8);
		waitResult();
		checkValue("inAddr", 8'h5a, inAddr);
		checkValue("inCmdCode", TCC_SEND, inCmdCode);
		checkValue("packetStart", 1, startCnt);
		checkValue("pushCount", 5, pushCnt);
		checkValue("packetEnd", 1, endCnt);
		checkValue("packetErr", 0, errCnt);
		endTest();

		startTest("badChecksum");
		txBuf[7] = txBuf[7] + 16'd1;
		spiFrame(8);
		waitResult();
		checkValue("endWithErr", 1, bothCnt);
		checkValue("packetEnd", 1, endCnt);
		endTest();

		startTest("abortedFrame");
		buildPacket(5);
		spiFrame(5); // header, size and three data words.
		waitResult();
		checkValue("packetErr", 1, errCnt);
		checkValue("packetEnd", 0, endCnt);
		clearCounts();
		buildPacket(5);
		spiFrame(8);
		waitResult();
		checkValue("pushCount", 5, pushCnt);
		checkValue("packetEnd", 1, endCnt);
		checkValue("packetErr", 0, errCnt);
		endTest();

		startTest("replyPacket");
		popIdx = 0;
		requestReply(16'd4);
		waitIdle();
		checkValue("popCount", 4, popCnt);
		checkValue("busyCycles", 11, busyCnt); // 2N+3 for N of 4.
		expWords[0] = {8'hc3, TCC_STATUS};
		expWords[1] = 16'd4;
		for (int i = 0; i < 4; i++)
			expWords[i + 2] = popTable[i];
		sum = 16'h0000;
		for (int i = 0; i < 6; i++)
			sum += expWords[i];
		expWords[6] = sum;
		expWords[7] = 16'h0000; // queue has run dry.
		for (int i = 0; i < 8; i++)
			txBuf[i] = 16'h0000;
		spiFrame(8);
		for (int i = 0; i < 8; i++)
			checkValue($sformatf("misoWord%0d", i), expWords[i], rxBuf[i]);
		endTest();

		startTest("txOverflow");
		requestReply(16'd20);
		waitIdle();
		checkValue("outQueueOverflow", 1, outQueueOverflow);
		waitClocks(20);
		checkValue("overflowHeld", 1, outQueueOverflow);
		endTest();

		startTest("resetState");
		requestReply(16'd4);
		waitClocks(2);
		rstN = 1'b0;
		waitClocks(5);
		rstN = 1'b1;
		checkValue("strobes", 0, {pushStrobe, popStrobe, inPacketStart, inPacketEnd, inPacketErr});
		checkValue("flags", 0, {inQueueOverflow, outQueueOverflow, spiIsBusy});
		checkValue("outBusy", 0, outBusy);
		checkValue("miso", 0, miso);
		spiFrame(2);
		checkValue("misoWord0", 0, rxBuf[0]);
		checkValue("misoWord1", 0, rxBuf[1]);
		endTest();

		errors += linkSpi_inst.svaChecks.failCount;
		$display("%0d of %0d tests passed, %0d errors", passed, tests, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: verilog.f
design/linkSpiPkg.sv
design/linkIf.sv
design/spiSlave.sv
design/txWordQueue.sv
design/protocolDecoder.sv
design/protocolEncoder.sv
design/linkSpi.sv
sim/linkSpi_sva.sv
sim/linkSpiTb.sv
